// ==== sources.f ====
hdl/eth_port_pkg.sv
hdl/eth_beat_if.sv
hdl/host_keep_encode.sv
hdl/frame_steer.sv
hdl/tail_keep_decode.sv
hdl/port_regs.sv
hdl/eth_ingress_top.sv
verification/tb_clock_gen.sv
verification/eth_ingress_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = eth_ingress_tb
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== verification/eth_ingress_tb.sv ====
// Self-checking testbench for the Ethernet ingress top; runs a frame table and register reads
`timescale 1ns/100ps
`default_nettype none

module eth_ingress_tb
  import eth_port_pkg::*;
();

  localparam reg_addr_t   TB_REG_BASE = 14'h40;
  localparam logic [7:0]  TB_PORT_NUM = 8'd5;
  localparam int unsigned RAND_SEED   = 32'hec80_7451;
  localparam int          PASSES      = 2;
  localparam int          NUM_FRAMES  = 14;
  localparam int          READY_LEN   = 4096;
  localparam int          DRAIN_LIMIT = 500;

  // Frame table entry where a nonzero odd_keep gives the last beat a non-contiguous tkeep
  typedef struct packed {
    logic [15:0] len;
    logic [15:0] etype;
    logic [7:0]  seed;
    keep_t       odd_keep;
    logic        to_arp;
  } frame_t;

  // One expected output beat
  typedef struct packed {
    word_t data;
    keep_t keep;
    logic  last;
  } beat_t;

  // Length, EtherType, payload seed, odd keep, expected port (1 means ARP)
  localparam frame_t FRAMES [NUM_FRAMES] = '{
    '{16'd64,  16'h0806, 8'h11, 8'h00, 1'b1},
    '{16'd60,  16'h0800, 8'h22, 8'h00, 1'b0},
    '{16'd8,   16'h0800, 8'h33, 8'h00, 1'b0},
    '{16'd5,   16'h0806, 8'h44, 8'h00, 1'b0},
    '{16'd42,  16'h0806, 8'h55, 8'h00, 1'b1},
    '{16'd47,  16'h86DD, 8'h66, 8'h00, 1'b0},
    '{16'd17,  16'h0806, 8'h77, 8'h00, 1'b1},
    '{16'd22,  16'h0800, 8'h88, 8'h00, 1'b0},
    '{16'd43,  16'h0806, 8'h99, 8'h00, 1'b1},
    '{16'd29,  16'h0800, 8'hAA, 8'h00, 1'b0},
    '{16'd24,  16'h0800, 8'hBB, 8'h05, 1'b0},
    '{16'd30,  16'h0806, 8'hCC, 8'hF0, 1'b1},
    '{16'd100, 16'h0806, 8'hDD, 8'h00, 1'b1},
    '{16'd3,   16'h88CC, 8'hEE, 8'h00, 1'b0}
  };

  logic      bus_clk;
  logic      reset;
  word_t     h2e_tdata;
  keep_t     h2e_tkeep;
  logic      h2e_tlast;
  logic      h2e_tvalid;
  logic      h2e_tready;
  word_t     arp_tdata;
  keep_t     arp_tkeep;
  logic      arp_tlast;
  logic      arp_tvalid;
  logic      arp_tready;
  word_t     net_tdata;
  keep_t     net_tkeep;
  logic      net_tlast;
  logic      net_tvalid;
  logic      net_tready;
  logic      reg_rd_req;
  reg_addr_t reg_rd_addr;
  logic      reg_rd_resp;
  reg_data_t reg_rd_data;

  // Expected beats per port are consumed by index as beats emerge
  beat_t      arp_q[$];
  beat_t      net_q[$];
  int         arp_got = 0;
  int         net_got = 0;
  logic       random_ready;
  logic [1:0] ready_pat [READY_LEN];

  tb_clock_gen clock_gen_i (
    .bus_clk (bus_clk),
    .reset   (reset)
  );

  eth_ingress_top #(
    .REG_BASE (TB_REG_BASE),
    .PORT_NUM (TB_PORT_NUM)
  ) UUT (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .h2e_tdata   (h2e_tdata),
    .h2e_tkeep   (h2e_tkeep),
    .h2e_tlast   (h2e_tlast),
    .h2e_tvalid  (h2e_tvalid),
    .h2e_tready  (h2e_tready),
    .arp_tdata   (arp_tdata),
    .arp_tkeep   (arp_tkeep),
    .arp_tlast   (arp_tlast),
    .arp_tvalid  (arp_tvalid),
    .arp_tready  (arp_tready),
    .net_tdata   (net_tdata),
    .net_tkeep   (net_tkeep),
    .net_tlast   (net_tlast),
    .net_tvalid  (net_tvalid),
    .net_tready  (net_tready),
    .reg_rd_req  (reg_rd_req),
    .reg_rd_addr (reg_rd_addr),
    .reg_rd_resp (reg_rd_resp),
    .reg_rd_data (reg_rd_data)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------

  // Bytes 12 and 13 hold the EtherType with the high byte first
  function automatic logic [7:0] frame_byte(input frame_t f, input int idx);
    logic [7:0] b;
    if (idx == 12) b = f.etype[15:8];
    else if (idx == 13) b = f.etype[7:0];
    else b = f.seed ^ 8'(idx * 29) ^ 8'(idx >> 3);
    return b;
  endfunction

  function automatic int beat_count(input frame_t f);
    return (int'(f.len) + 7) / 8;
  endfunction

  // Byte 0 of the beat in the low lane
  function automatic word_t beat_word(input frame_t f, input int b);
    word_t w;
    int    lane;
    for (lane = 0; lane < 8; lane++) w[lane*8 +: 8] = frame_byte(f, b * 8 + lane);
    return w;
  endfunction

  // Host tkeep is full mid-frame and holds the low bytes of the remainder on the last beat
  function automatic keep_t host_keep(input frame_t f, input int b);
    keep_t k;
    int    i;
    int    rem;
    k   = 8'hFF;
    rem = int'(f.len) % 8;
    if (b == beat_count(f) - 1) begin
      if (f.odd_keep != 8'h00) begin
        k = f.odd_keep;
      end else if (rem != 0) begin
        k = 8'h00;
        for (i = 0; i < rem; i++) k[i] = 1'b1;
      end
    end
    return k;
  endfunction

  // A non-contiguous tail has no tail count, so it leaves as a full beat
  function automatic keep_t expect_keep(input frame_t f, input int b);
    if (f.odd_keep != 8'h00) return 8'hFF;
    return host_keep(f, b);
  endfunction

  function automatic int total_beats();
    int i;
    int n;
    n = 0;
    for (i = 0; i < NUM_FRAMES; i++) n += beat_count(FRAMES[i]);
    return n;
  endfunction

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_beat(input string port, input beat_t exp, input word_t data,
                            input keep_t keep, input logic last);
    if (data !== exp.data) begin
      $display("FAILED at %0t: %s_tdata expected %h, got %h", $time, port, exp.data, data);
      abort_run();
    end
    if (keep !== exp.keep) begin
      $display("FAILED at %0t: %s_tkeep expected %h, got %h", $time, port, exp.keep, keep);
      abort_run();
    end
    if (last !== exp.last) begin
      $display("FAILED at %0t: %s_tlast expected %b, got %b", $time, port, exp.last, last);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Output monitors sample at the edge where the beat transfers
  always @(posedge bus_clk) begin
    if (!reset && arp_tvalid && arp_tready) begin
      if (arp_got >= arp_q.size()) begin
        $display("Unexpected beat on the ARP port at %0t", $time);
        abort_run();
      end
      check_beat("arp", arp_q[arp_got], arp_tdata, arp_tkeep, arp_tlast);
      arp_got <= arp_got + 1;
    end
  end

  always @(posedge bus_clk) begin
    if (!reset && net_tvalid && net_tready) begin
      if (net_got >= net_q.size()) begin
        $display("Unexpected beat on the network port at %0t", $time);
        abort_run();
      end
      check_beat("net", net_q[net_got], net_tdata, net_tkeep, net_tlast);
      net_got <= net_got + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Output ready stays high or follows the precomputed random pattern
  initial begin
    int rdy_idx;
    rdy_idx = 0;
    arp_tready <= 1'b1;
    net_tready <= 1'b1;
    forever begin
      @(posedge bus_clk);
      if (random_ready) begin
        arp_tready <= ready_pat[rdy_idx][0];
        net_tready <= ready_pat[rdy_idx][1];
        rdy_idx = (rdy_idx + 1) % READY_LEN;
      end else begin
        arp_tready <= 1'b1;
        net_tready <= 1'b1;
      end
    end
  end

  // Queue the expected beats, then drive the frame with the host handshake
  task automatic send_frame(input frame_t f);
    int    b;
    int    nb;
    beat_t e;
    nb = beat_count(f);
    for (b = 0; b < nb; b++) begin
      e.data = beat_word(f, b);
      e.keep = expect_keep(f, b);
      e.last = (b == nb - 1);
      if (f.to_arp) arp_q.push_back(e);
      else net_q.push_back(e);
    end
    for (b = 0; b < nb; b++) begin
      h2e_tdata  <= beat_word(f, b);
      h2e_tkeep  <= host_keep(f, b);
      h2e_tlast  <= (b == nb - 1);
      h2e_tvalid <= 1'b1;
      do @(posedge bus_clk); while (!h2e_tready);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((arp_got != arp_q.size() || net_got != net_q.size()) && n < DRAIN_LIMIT) begin
      @(posedge bus_clk);
      n++;
    end
    if (arp_got != arp_q.size() || net_got != net_q.size()) begin
      $display("Frames incomplete: %0d ARP and %0d network beats never arrived",
               arp_q.size() - arp_got, net_q.size() - net_got);
      abort_run();
    end
    // Idle gap so that any extra beat shows up
    repeat (10) @(posedge bus_clk);
  endtask

  // Request at one edge and expect the response at the following edge only
  task automatic read_reg(input reg_addr_t addr, input logic exp_resp,
                          input reg_data_t exp_data);
    reg_rd_req  <= 1'b1;
    reg_rd_addr <= addr;
    @(posedge bus_clk);
    reg_rd_req  <= 1'b0;
    check_flag("reg_rd_resp", 1'b0, reg_rd_resp);
    @(posedge bus_clk);
    check_flag("reg_rd_resp", exp_resp, reg_rd_resp);
    check_reg("reg_rd_data", exp_data, reg_rd_data);
    @(posedge bus_clk);
    check_flag("reg_rd_resp", 1'b0, reg_rd_resp);
  endtask

  initial begin
    int i;
    int pass;
    h2e_tdata    <= '0;
    h2e_tkeep    <= '0;
    h2e_tlast    <= 1'b0;
    h2e_tvalid   <= 1'b0;
    reg_rd_req   <= 1'b0;
    reg_rd_addr  <= '0;
    random_ready <= 1'b0;
    void'($urandom(RAND_SEED));
    // Roughly one stall in four on each port
    for (i = 0; i < READY_LEN; i++) ready_pat[i] = {($urandom % 4) != 0, ($urandom % 4) != 0};
    @(posedge bus_clk);
    while (reset) @(posedge bus_clk);

    // First pass runs with outputs always ready and the second with random stalls
    for (pass = 0; pass < PASSES; pass++) begin
      random_ready <= (pass == 1);
      for (i = 0; i < NUM_FRAMES; i++) send_frame(FRAMES[i]);
      h2e_tvalid <= 1'b0;
      h2e_tlast  <= 1'b0;
      wait_drain();
    end
    random_ready <= 1'b0;

    read_reg(TB_REG_BASE + REG_PORT_INFO, 1'b1, {24'd0, TB_PORT_NUM});
    read_reg(TB_REG_BASE + REG_MAC_CTRL_STATUS, 1'b1, 32'd0);
    read_reg(TB_REG_BASE + REG_PHY_CTRL_STATUS, 1'b1, 32'd0);
    read_reg(TB_REG_BASE + REG_MAC_LED_CTL, 1'b1, 32'd0);
    read_reg(14'h50, 1'b0, 32'd0);
    read_reg(14'h3C, 1'b0, 32'd0);

    $display("Testbench passed");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int limit;
    limit = 40 * PASSES * total_beats() + 200;
    repeat (limit) @(posedge bus_clk);
    $display("Timeout: run did not finish within %0d cycles", limit);
    abort_run();
  end

endmodule : eth_ingress_tb

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset source; instantiate once in the testbench top to drive bus_clk and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 2
) (
  output logic bus_clk,
  output logic reset
);

  // 8 ns period
  initial begin
    bus_clk = 1'b0;
    forever #(HALF_PERIOD) bus_clk = ~bus_clk;
  end

  // Reset held high for the first rising edges
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    reset <= 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== hdl/eth_ingress_top.sv ====
// Host ingress top: steers host frames to ARP or network keep streams, plus the port register stub
`timescale 1ns/100ps
`default_nettype none

module eth_ingress_top
  import eth_port_pkg::*;
#(
  parameter reg_addr_t  REG_BASE = 14'h0,
  parameter logic [7:0] PORT_NUM = 8'd0
) (
  input  wire       bus_clk,
  input  wire       reset,

  // Host DMA stream in
  input  word_t     h2e_tdata,
  input  keep_t     h2e_tkeep,
  input  wire       h2e_tlast,
  input  wire       h2e_tvalid,
  output logic      h2e_tready,

  // ARP responder stream out
  output word_t     arp_tdata,
  output keep_t     arp_tkeep,
  output logic      arp_tlast,
  output logic      arp_tvalid,
  input  wire       arp_tready,

  // Network transport stream out
  output word_t     net_tdata,
  output keep_t     net_tkeep,
  output logic      net_tlast,
  output logic      net_tvalid,
  input  wire       net_tready,

  // Register read port
  input  wire       reg_rd_req,
  input  reg_addr_t reg_rd_addr,
  output logic      reg_rd_resp,
  output reg_data_t reg_rd_data
);

  // ---------------------------------------------------------------------------
  // Stream pipeline
  // ---------------------------------------------------------------------------

  eth_beat_if enc_s ();
  eth_beat_if arp_s ();
  eth_beat_if net_s ();

  host_keep_encode keep_encode_i (
    .bus_clk    (bus_clk),
    .reset      (reset),
    .h2e_tdata  (h2e_tdata),
    .h2e_tkeep  (h2e_tkeep),
    .h2e_tlast  (h2e_tlast),
    .h2e_tvalid (h2e_tvalid),
    .h2e_tready (h2e_tready),
    .enc        (enc_s.src)
  );

  frame_steer frame_steer_i (
    .bus_clk (bus_clk),
    .reset   (reset),
    .enc     (enc_s.dst),
    .arp     (arp_s.src),
    .net     (net_s.src)
  );

  // One decode stage per output port
  tail_keep_decode arp_decode_i (
    .bus_clk (bus_clk),
    .reset   (reset),
    .beat    (arp_s.dst),
    .tdata   (arp_tdata),
    .tkeep   (arp_tkeep),
    .tlast   (arp_tlast),
    .tvalid  (arp_tvalid),
    .tready  (arp_tready)
  );

  tail_keep_decode net_decode_i (
    .bus_clk (bus_clk),
    .reset   (reset),
    .beat    (net_s.dst),
    .tdata   (net_tdata),
    .tkeep   (net_tkeep),
    .tlast   (net_tlast),
    .tvalid  (net_tvalid),
    .tready  (net_tready)
  );

  // ---------------------------------------------------------------------------
  // Port registers
  // ---------------------------------------------------------------------------

  port_regs #(
    .REG_BASE (REG_BASE),
    .PORT_NUM (PORT_NUM)
  ) port_regs_i (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .reg_rd_req  (reg_rd_req),
    .reg_rd_addr (reg_rd_addr),
    .reg_rd_resp (reg_rd_resp),
    .reg_rd_data (reg_rd_data)
  );

endmodule : eth_ingress_top

`default_nettype wire

// ==== hdl/port_regs.sv ====
// Stub of the four driver port registers; answers reads at REG_BASE one cycle after the request
`timescale 1ns/100ps
`default_nettype none

module port_regs
  import eth_port_pkg::*;
#(
  parameter reg_addr_t   REG_BASE = 14'h0,
  parameter logic [7:0]  PORT_NUM = 8'd0
) (
  input  wire       bus_clk,
  input  wire       reset,
  input  wire       reg_rd_req,
  input  reg_addr_t reg_rd_addr,
  output logic      reg_rd_resp,
  output reg_data_t reg_rd_data
);

  // Absolute byte addresses of the four registers
  localparam reg_addr_t ADDR_PORT_INFO  = REG_BASE + REG_PORT_INFO;
  localparam reg_addr_t ADDR_MAC_STATUS = REG_BASE + REG_MAC_CTRL_STATUS;
  localparam reg_addr_t ADDR_PHY_STATUS = REG_BASE + REG_PHY_CTRL_STATUS;
  localparam reg_addr_t ADDR_LED_CTL    = REG_BASE + REG_MAC_LED_CTL;

  // Compare on the word address and ignore the byte lane bits
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      reg_rd_resp <= 1'b0;
      reg_rd_data <= '0;
    end else begin
      reg_rd_resp <= 1'b0;
      reg_rd_data <= '0;
      if (reg_rd_req) begin
        case (reg_rd_addr[13:2])
          ADDR_PORT_INFO[13:2]: begin
            reg_rd_resp <= 1'b1;
            // Port number in the low byte
            reg_rd_data <= {24'd0, PORT_NUM};
          end
          ADDR_MAC_STATUS[13:2],
          ADDR_PHY_STATUS[13:2],
          ADDR_LED_CTL[13:2]: begin
            // Nothing to report so these read as zero
            reg_rd_resp <= 1'b1;
          end
          default: reg_rd_resp <= 1'b0;
        endcase
      end
    end
  end

endmodule : port_regs

`default_nettype wire

// ==== hdl/tail_keep_decode.sv ====
// Output stage: registers one beat and expands its tail count back into tkeep
`timescale 1ns/100ps
`default_nettype none

module tail_keep_decode
  import eth_port_pkg::*;
(
  input  wire     bus_clk,
  input  wire     reset,
  eth_beat_if.dst beat,
  output word_t   tdata,
  output keep_t   tkeep,
  output logic    tlast,
  output logic    tvalid,
  input  wire     tready
);

  // Mid-frame beats and tail 0 are full, otherwise the low tail bytes
  function automatic keep_t tail_to_keep(input tail_t tail, input logic last);
    keep_t keep;
    keep = 8'hFF;
    if (last && (tail != 4'd0)) begin
      keep = keep_t'((9'h001 << tail[2:0]) - 9'h001);
    end
    return keep;
  endfunction

  // Room when empty or when the downstream takes the current beat
  assign beat.tready = !tvalid || tready;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      tvalid <= 1'b0;
    end else if (beat.tvalid && beat.tready) begin
      tvalid <= 1'b1;
    end else if (tready) begin
      tvalid <= 1'b0;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (beat.tvalid && beat.tready) begin
      tdata <= beat.tdata;
      tkeep <= tail_to_keep(beat.tuser, beat.tlast);
      tlast <= beat.tlast;
    end
  end

  // Tail count set by the encoder must survive the router untouched
  a_tail_on_last : assert property (@(posedge bus_clk) disable iff (reset)
    (beat.tvalid && !beat.tlast) |-> (beat.tuser == 4'd0));

endmodule : tail_keep_decode

`default_nettype wire

// ==== hdl/frame_steer.sv ====
// Frame router: reads the EtherType from beat 1 and sends each frame to the ARP or network stream
`timescale 1ns/100ps
`default_nettype none

module frame_steer
  import eth_port_pkg::*;
(
  input  wire     bus_clk,
  input  wire     reset,
  eth_beat_if.dst enc,
  eth_beat_if.src arp,
  eth_beat_if.src net
);

  // Idle with nothing held, beat 0 held awaiting beat 1, or frame routed
  typedef enum logic [1:0] {
    S_IDLE,
    S_FIRST,
    S_ROUTE
  } state_t;

  state_t state;
  logic   route_arp;

  // Single held beat
  word_t  hold_data;
  tail_t  hold_user;
  logic   hold_last;
  logic   hold_valid;

  logic   out_ready;
  logic   leave;
  logic   load;
  logic   enc_is_arp;

  // ---------------------------------------------------------------------------
  // Handshake
  // ---------------------------------------------------------------------------

  assign out_ready  = route_arp ? arp.tready : net.tready;
  assign leave      = hold_valid && (state == S_ROUTE) && out_ready;
  // Beat 1 is only inspected in S_FIRST, it waits at the encoder output
  assign enc.tready = (state == S_IDLE) || ((state == S_ROUTE) && (!hold_valid || out_ready));
  assign load       = enc.tvalid && enc.tready;

  // EtherType is frame bytes 12 and 13, lanes 4 and 5 of beat 1, MSB first
  assign enc_is_arp = ({enc.tdata[39:32], enc.tdata[47:40]} == ETHERTYPE_ARP);

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      state      <= S_IDLE;
      route_arp  <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (load) begin
            hold_valid <= 1'b1;
            route_arp  <= 1'b0;
            // One-beat frame has no EtherType, straight to net
            state      <= enc.tlast ? S_ROUTE : S_FIRST;
          end
        end
        S_FIRST: begin
          if (enc.tvalid) begin
            route_arp <= enc_is_arp;
            state     <= S_ROUTE;
          end
        end
        S_ROUTE: begin
          if (load) begin
            hold_valid <= 1'b1;
            // Last beat leaves while the next frame's beat 0 comes in
            if (hold_valid && hold_last) begin
              route_arp <= 1'b0;
              state     <= enc.tlast ? S_ROUTE : S_FIRST;
            end
          end else if (leave) begin
            hold_valid <= 1'b0;
            if (hold_last) begin
              state <= S_IDLE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clk) begin
    if (load) begin
      hold_data <= enc.tdata;
      hold_user <= enc.tuser;
      hold_last <= enc.tlast;
    end
  end

  // ---------------------------------------------------------------------------
  // Outputs, both carry the held beat and only the routed one is valid
  // ---------------------------------------------------------------------------

  assign arp.tdata  = hold_data;
  assign arp.tuser  = hold_user;
  assign arp.tlast  = hold_last;
  assign arp.tvalid = hold_valid && (state == S_ROUTE) && route_arp;

  assign net.tdata  = hold_data;
  assign net.tuser  = hold_user;
  assign net.tlast  = hold_last;
  assign net.tvalid = hold_valid && (state == S_ROUTE) && !route_arp;

  a_one_port : assert property (@(posedge bus_clk) disable iff (reset)
    !(arp.tvalid && net.tvalid));

  // Stalled ARP beat stays put until taken
  a_arp_hold : assert property (@(posedge bus_clk) disable iff (reset)
    (arp.tvalid && !arp.tready) |=> (arp.tvalid && $stable(arp.tdata)));

endmodule : frame_steer

`default_nettype wire

// ==== hdl/host_keep_encode.sv ====
// Input stage: registers host DMA beats and converts last-beat tkeep into a tail count
`timescale 1ns/100ps
`default_nettype none

module host_keep_encode
  import eth_port_pkg::*;
(
  input  wire     bus_clk,
  input  wire     reset,
  input  word_t   h2e_tdata,
  input  keep_t   h2e_tkeep,
  input  wire     h2e_tlast,
  input  wire     h2e_tvalid,
  output logic    h2e_tready,
  eth_beat_if.src enc
);

  // Low-justified contiguous masks map to their byte count
  // Full mask and any odd pattern give zero, the full-beat code
  function automatic tail_t keep_to_tail(input keep_t keep, input logic last);
    tail_t tail;
    tail = '0;
    if (last) begin
      case (keep)
        8'b0000_0001: tail = 4'd1;
        8'b0000_0011: tail = 4'd2;
        8'b0000_0111: tail = 4'd3;
        8'b0000_1111: tail = 4'd4;
        8'b0001_1111: tail = 4'd5;
        8'b0011_1111: tail = 4'd6;
        8'b0111_1111: tail = 4'd7;
        default:      tail = 4'd0;
      endcase
    end
    return tail;
  endfunction

  // Accept when the register is empty or drains this cycle
  assign h2e_tready = !enc.tvalid || enc.tready;

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      enc.tvalid <= 1'b0;
    end else if (h2e_tvalid && h2e_tready) begin
      enc.tvalid <= 1'b1;
    end else if (enc.tready) begin
      enc.tvalid <= 1'b0;
    end
  end

  // Beat payload
  always_ff @(posedge bus_clk) begin
    if (h2e_tvalid && h2e_tready) begin
      enc.tdata <= h2e_tdata;
      enc.tuser <= keep_to_tail(h2e_tkeep, h2e_tlast);
      enc.tlast <= h2e_tlast;
    end
  end

  // Host DMA only shortens the final beat of a frame
  a_full_keep_mid_frame : assert property (@(posedge bus_clk) disable iff (reset)
    (h2e_tvalid && !h2e_tlast) |-> (h2e_tkeep == 8'hFF));

endmodule : host_keep_encode

`default_nettype wire

// ==== hdl/eth_beat_if.sv ====
// Internal beat stream with tail count in tuser; instantiate per link, src drives, dst accepts
`timescale 1ns/100ps
`default_nettype none

interface eth_beat_if
  import eth_port_pkg::*;
();

  // Payload of one beat
  word_t tdata;
  // Tail count, only nonzero on a last beat
  tail_t tuser;
  logic  tlast;

  // Handshake, transfer when both are high at a clock edge
  logic  tvalid;
  logic  tready;

  // Producer side
  modport src (
    output tdata, tuser, tlast, tvalid,
    input  tready
  );

  // Consumer side
  modport dst (
    input  tdata, tuser, tlast, tvalid,
    output tready
  );

endinterface : eth_beat_if

`default_nettype wire

// ==== hdl/eth_port_pkg.sv ====
// Shared beat, tail and register types plus constants for the Ethernet ingress; import with ::*
`default_nettype none

package eth_port_pkg;

  // --------------------------------------------------------------------------
  // Stream payload types
  // --------------------------------------------------------------------------

  // One 64-bit beat, frame byte 0 in bits 7..0
  typedef logic [63:0] word_t;

  // Host byte enables, one bit per byte lane
  typedef logic [7:0] keep_t;

  // Tail count on a last beat
  // 0 means all eight bytes, 1 to 7 means that many low bytes
  typedef logic [3:0] tail_t;

  // EtherType that selects the ARP responder path
  localparam logic [15:0] ETHERTYPE_ARP = 16'h0806;

  // --------------------------------------------------------------------------
  // Register port
  // --------------------------------------------------------------------------

  // Byte address and read data of the register port
  typedef logic [13:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Offsets of the four driver registers, relative to the block base
  localparam reg_addr_t REG_PORT_INFO       = 14'h0;
  localparam reg_addr_t REG_MAC_CTRL_STATUS = 14'h4;
  localparam reg_addr_t REG_PHY_CTRL_STATUS = 14'h8;
  localparam reg_addr_t REG_MAC_LED_CTL     = 14'hC;

endpackage : eth_port_pkg

`default_nettype wire
